// File: cache_pkg.sv
package cache_pkg;

    localparam int WORD_W     = 16;
    localparam int LINE_COUNT = 8;
    localparam int LINE_WORDS = 4;

    // Address split, top to bottom: tag, index, word offset
    localparam int OFFSET_W = $clog2(LINE_WORDS);
    localparam int INDEX_W  = $clog2(LINE_COUNT);
    localparam int TAG_W    = WORD_W - INDEX_W - OFFSET_W;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [WORD_W-1:0]   addr_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // Tag and index together name one line in memory
    typedef logic [TAG_W+INDEX_W-1:0] line_addr_t;

endpackage

// File: mem_pkg.sv
package mem_pkg;

    import cache_pkg::*;

    // Word 0 of a line sits in the top bits
    localparam int LINE_W = LINE_WORDS * WORD_W;

    localparam int    MEM_LINES    = 64;
    localparam int    MEM_ADDR_W   = $clog2(MEM_LINES);
    localparam int    MEM_LATENCY  = 3;
    localparam int    LAT_W        = $clog2(MEM_LATENCY + 1);
    localparam word_t INIT_PATTERN = 16'h5a5a;

    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [LAT_W-1:0]      lat_cnt_t;

endpackage

// File: icache.sv
`timescale 1ns/10ps

module icache (
    input  logic                  Clk,
    input  logic                  i_arst_n,
    input  logic                  i_read,
    input  cache_pkg::addr_t      i_addr,
    output cache_pkg::word_t      o_data,
    output logic                  o_done,
    output logic                  o_mem_read,
    output cache_pkg::line_addr_t o_mem_line_addr,
    input  logic                  i_mem_busy,
    input  mem_pkg::line_t        i_mem_line
);

    import cache_pkg::*;
    import mem_pkg::*;

    tag_t                  tag_q  [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_q;
    word_t                 data_q [LINE_COUNT][LINE_WORDS];

    tag_t    addr_tag;
    index_t  addr_index;
    offset_t addr_offset;
    logic    hit;
    logic    fill;

    assign {addr_tag, addr_index, addr_offset} = i_addr;

    assign hit             = valid_q[addr_index] && (tag_q[addr_index] == addr_tag);
    assign o_mem_read      = i_read && !hit;
    assign o_mem_line_addr = {addr_tag, addr_index};

    // Line from memory is good at the edge where busy has dropped
    assign fill = o_mem_read && !i_mem_busy;

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= '0;
            o_done  <= 1'b0;
        end else begin
            if (fill) begin
                valid_q[addr_index] <= 1'b1;
            end
            // One pulse per held request
            o_done <= i_read && hit && !o_done;
        end
    end

    always_ff @(posedge Clk) begin
        if (fill) begin
            tag_q[addr_index] <= addr_tag;
            for (int w = 0; w < LINE_WORDS; w++) begin
                data_q[addr_index][w] <= i_mem_line[LINE_W-1-w*WORD_W -: WORD_W];
            end
        end
        if (i_read && hit) begin
            o_data <= data_q[addr_index][addr_offset];
        end
    end

    // ************************************************************************
    // Checks
    // ************************************************************************

    assert property (@(posedge Clk) disable iff (!i_arst_n) o_done |-> $past(i_read))
        else $error("icache: done pulse without a held fetch");

endmodule

// File: dcache.sv
`timescale 1ns/10ps

module dcache (
    input  logic                  Clk,
    input  logic                  i_arst_n,
    input  logic                  i_read,
    input  logic                  i_write,
    input  cache_pkg::addr_t      i_addr,
    input  cache_pkg::word_t      i_wdata,
    output cache_pkg::word_t      o_rdata,
    output logic                  o_done,
    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output cache_pkg::line_addr_t o_mem_line_addr,
    output mem_pkg::line_t        o_mem_wline,
    input  logic                  i_mem_busy,
    input  mem_pkg::line_t        i_mem_rline
);

    import cache_pkg::*;
    import mem_pkg::*;

    tag_t                  tag_q  [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_q;
    logic [LINE_COUNT-1:0] dirty_q;
    word_t                 data_q [LINE_COUNT][LINE_WORDS];

    tag_t    addr_tag;
    index_t  addr_index;
    offset_t addr_offset;
    logic    req;
    logic    hit;
    logic    victim_dirty;
    logic    fill;
    logic    evict_done;
    logic    serve;

    assign {addr_tag, addr_index, addr_offset} = i_addr;

    assign req          = i_read || i_write;
    assign hit          = valid_q[addr_index] && (tag_q[addr_index] == addr_tag);
    assign victim_dirty = valid_q[addr_index] && dirty_q[addr_index];

    // A dirty victim goes back to memory before the refill starts
    assign o_mem_write = req && !hit && victim_dirty;
    assign o_mem_read  = req && !hit && !victim_dirty;

    assign o_mem_line_addr = o_mem_write ? {tag_q[addr_index], addr_index}
                                         : {addr_tag, addr_index};

    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            o_mem_wline[LINE_W-1-w*WORD_W -: WORD_W] = data_q[addr_index][w];
        end
    end

    assign fill       = o_mem_read && !i_mem_busy;
    assign evict_done = o_mem_write && !i_mem_busy;
    assign serve      = req && hit && !o_done;

    // ************************************************************************
    // Line state
    // ************************************************************************

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            o_done  <= 1'b0;
        end else begin
            if (evict_done) begin
                dirty_q[addr_index] <= 1'b0;
            end
            if (fill) begin
                valid_q[addr_index] <= 1'b1;
                dirty_q[addr_index] <= 1'b0;
            end
            if (serve && i_write) begin
                dirty_q[addr_index] <= 1'b1;
            end
            o_done <= serve;
        end
    end

    // Tags, words and read data
    always_ff @(posedge Clk) begin
        if (fill) begin
            tag_q[addr_index] <= addr_tag;
            for (int w = 0; w < LINE_WORDS; w++) begin
                data_q[addr_index][w] <= i_mem_rline[LINE_W-1-w*WORD_W -: WORD_W];
            end
        end
        if (serve && i_write) begin
            data_q[addr_index][addr_offset] <= i_wdata;
        end
        if (req && hit && i_read) begin
            o_rdata <= data_q[addr_index][addr_offset];
        end
    end

    // ************************************************************************
    // Checks
    // ************************************************************************

    assert property (@(posedge Clk) disable iff (!i_arst_n) !(o_mem_read && o_mem_write))
        else $error("dcache: memory read and write requested together");

    assert property (@(posedge Clk) disable iff (!i_arst_n) !(i_read && i_write))
        else $error("dcache: processor holds read and write together");

endmodule

// File: line_memory.sv
`timescale 1ns/10ps

module line_memory (
    input  logic                  Clk,
    input  logic                  i_arst_n,
    input  logic                  i_p1_read,
    input  cache_pkg::line_addr_t i_p1_line_addr,
    output logic                  o_p1_busy,
    output mem_pkg::line_t        o_p1_line,
    input  logic                  i_p2_read,
    input  logic                  i_p2_write,
    input  cache_pkg::line_addr_t i_p2_line_addr,
    input  mem_pkg::line_t        i_p2_wline,
    output logic                  o_p2_busy,
    output mem_pkg::line_t        o_p2_rline
);

    import cache_pkg::*;
    import mem_pkg::*;

    line_t           mem_q [MEM_LINES];
    lat_cnt_t [1:0]  cnt_q;
    logic     [1:0]  port_req;
    logic     [1:0]  port_busy;
    mem_addr_t       p1_addr;
    mem_addr_t       p2_addr;

    // Line addresses wrap at the memory depth
    assign p1_addr = i_p1_line_addr[MEM_ADDR_W-1:0];
    assign p2_addr = i_p2_line_addr[MEM_ADDR_W-1:0];

    assign port_req = {i_p2_read || i_p2_write, i_p1_read};

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            port_busy[p] = port_req[p] && (cnt_q[p] != lat_cnt_t'(MEM_LATENCY));
        end
    end

    // Counter restarts after each completed access
    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt_q <= '0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (!port_busy[p]) begin
                    cnt_q[p] <= '0;
                end else begin
                    cnt_q[p] <= cnt_q[p] + lat_cnt_t'(1);
                end
            end
        end
    end

    assign o_p1_busy  = port_busy[0];
    assign o_p2_busy  = port_busy[1];
    assign o_p1_line  = mem_q[p1_addr];
    assign o_p2_rline = mem_q[p2_addr];

    // Word a starts out as a xor INIT_PATTERN
    initial begin
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                mem_q[l][LINE_W-1-w*WORD_W -: WORD_W] = word_t'(l*LINE_WORDS + w) ^ INIT_PATTERN;
            end
        end
    end

    always @(posedge Clk) begin
        if (i_p2_write && !port_busy[1]) begin
            mem_q[p2_addr] <= i_p2_wline;
        end
    end

    assert property (@(posedge Clk) disable iff (!i_arst_n) !(i_p2_read && i_p2_write))
        else $error("line_memory: port 2 read and write at once");

endmodule

// File: cache_top.sv
`timescale 1ns/10ps

module cache_top (
    input  logic             Clk,
    input  logic             i_arst_n,
    input  logic             i_i_read,
    input  cache_pkg::addr_t i_i_addr,
    output cache_pkg::word_t o_i_data,
    output logic             o_i_done,
    input  logic             i_d_read,
    input  logic             i_d_write,
    input  cache_pkg::addr_t i_d_addr,
    input  cache_pkg::word_t i_d_wdata,
    output cache_pkg::word_t o_d_rdata,
    output logic             o_d_done
);

    import cache_pkg::*;
    import mem_pkg::*;

    // Instruction memory port
    logic       mem1_read;
    line_addr_t mem1_line_addr;
    logic       mem1_busy;
    line_t      mem1_line;

    // Data memory port
    logic       mem2_read;
    logic       mem2_write;
    line_addr_t mem2_line_addr;
    line_t      mem2_wline;
    logic       mem2_busy;
    line_t      mem2_rline;

    icache u_icache (
        .Clk             (Clk),
        .i_arst_n        (i_arst_n),
        .i_read          (i_i_read),
        .i_addr          (i_i_addr),
        .o_data          (o_i_data),
        .o_done          (o_i_done),
        .o_mem_read      (mem1_read),
        .o_mem_line_addr (mem1_line_addr),
        .i_mem_busy      (mem1_busy),
        .i_mem_line      (mem1_line)
    );

    dcache u_dcache (
        .Clk             (Clk),
        .i_arst_n        (i_arst_n),
        .i_read          (i_d_read),
        .i_write         (i_d_write),
        .i_addr          (i_d_addr),
        .i_wdata         (i_d_wdata),
        .o_rdata         (o_d_rdata),
        .o_done          (o_d_done),
        .o_mem_read      (mem2_read),
        .o_mem_write     (mem2_write),
        .o_mem_line_addr (mem2_line_addr),
        .o_mem_wline     (mem2_wline),
        .i_mem_busy      (mem2_busy),
        .i_mem_rline     (mem2_rline)
    );

    line_memory u_line_memory (
        .Clk            (Clk),
        .i_arst_n       (i_arst_n),
        .i_p1_read      (mem1_read),
        .i_p1_line_addr (mem1_line_addr),
        .o_p1_busy      (mem1_busy),
        .o_p1_line      (mem1_line),
        .i_p2_read      (mem2_read),
        .i_p2_write     (mem2_write),
        .i_p2_line_addr (mem2_line_addr),
        .i_p2_wline     (mem2_wline),
        .o_p2_busy      (mem2_busy),
        .o_p2_rline     (mem2_rline)
    );

endmodule

// File: tb_checker.sv
`timescale 1ns/10ps

module tb_checker (
    input  logic             Clk,
    input  logic             i_ifetch_read,
    input  logic             i_data_read,
    input  logic             i_data_write,
    input  logic             i_ifetch_done,
    input  cache_pkg::word_t i_ifetch_data,
    input  logic             i_data_done,
    input  cache_pkg::word_t i_data_rdata,
    input  logic             i_expect_ifetch,
    input  logic             i_expect_load,
    input  logic             i_expect_store,
    input  cache_pkg::word_t i_expect_data,
    output int               o_data_errors,
    output int               o_protocol_errors
);

    int data_errors     = 0;
    int protocol_errors = 0;

    assign o_data_errors     = data_errors;
    assign o_protocol_errors = protocol_errors;

    // DUT outputs settle well before the falling edge
    always @(negedge Clk) begin
        if (i_ifetch_done) begin
            if (!(i_expect_ifetch && i_ifetch_read)) begin
                $display("Instruction done pulse at %0t while no fetch was held", $time);
                protocol_errors++;
            end else if (i_ifetch_data !== i_expect_data) begin
                $display("ERROR at %0t: o_i_data = %h, expected %h",
                         $time, i_ifetch_data, i_expect_data);
                data_errors++;
            end
        end
        if (i_data_done) begin
            if (!((i_expect_load && i_data_read) || (i_expect_store && i_data_write))) begin
                $display("Data done pulse at %0t while no load or store was held", $time);
                protocol_errors++;
            end else if (i_expect_load && (i_data_rdata !== i_expect_data)) begin
                $display("ERROR at %0t: o_d_rdata = %h, expected %h",
                         $time, i_data_rdata, i_expect_data);
                data_errors++;
            end
        end
    end

endmodule

// File: tb_cache_top.sv
`timescale 1ns/10ps

module tb_cache_top;

    import cache_pkg::*;
    import mem_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 2;
    localparam int IDLE_CYCLES     = 5;
    localparam int TABLE_LEN       = 18;
    localparam int MAX_WAIT        = MEM_LATENCY * 3 + 4;
    localparam int WATCHDOG_CYCLES = TABLE_LEN * (2 * MEM_LATENCY + 8) + RESET_CYCLES
                                     + IDLE_CYCLES;

    localparam logic [1:0] IFETCH = 2'd0;
    localparam logic [1:0] LOAD   = 2'd1;
    localparam logic [1:0] STORE  = 2'd2;

    logic  Clk;
    logic  i_arst_n;
    logic  ifetch_read;
    addr_t ifetch_addr;
    word_t ifetch_data;
    logic  ifetch_done;
    logic  data_read;
    logic  data_write;
    addr_t data_addr;
    word_t data_wdata;
    word_t data_rdata;
    logic  data_done;

    logic  chk_ifetch;
    logic  chk_load;
    logic  chk_store;
    word_t chk_exp;
    int    data_errors;
    int    protocol_errors;
    int    timeout_errors;
    int    tab_fill;

    integer seed;

    // Stimulus table: kind, address, write data, expected read value
    logic [1:0] tab_kind  [TABLE_LEN];
    addr_t      tab_addr  [TABLE_LEN];
    word_t      tab_wdata [TABLE_LEN];
    word_t      tab_exp   [TABLE_LEN];

    cache_top dut (
        .Clk       (Clk),
        .i_arst_n  (i_arst_n),
        .i_i_read  (ifetch_read),
        .i_i_addr  (ifetch_addr),
        .o_i_data  (ifetch_data),
        .o_i_done  (ifetch_done),
        .i_d_read  (data_read),
        .i_d_write (data_write),
        .i_d_addr  (data_addr),
        .i_d_wdata (data_wdata),
        .o_d_rdata (data_rdata),
        .o_d_done  (data_done)
    );

    tb_checker u_checker (
        .Clk               (Clk),
        .i_ifetch_read     (ifetch_read),
        .i_data_read       (data_read),
        .i_data_write      (data_write),
        .i_ifetch_done     (ifetch_done),
        .i_ifetch_data     (ifetch_data),
        .i_data_done       (data_done),
        .i_data_rdata      (data_rdata),
        .i_expect_ifetch   (chk_ifetch),
        .i_expect_load     (chk_load),
        .i_expect_store    (chk_store),
        .i_expect_data     (chk_exp),
        .o_data_errors     (data_errors),
        .o_protocol_errors (protocol_errors)
    );

    always #(CLK_PERIOD / 2) Clk = ~Clk;

    // Memory word a starts out as a xor 5a5a
    function automatic word_t pattern_word(input addr_t a);
        return a ^ 16'h5a5a;
    endfunction

    task automatic add_entry(input logic [1:0] kind, input addr_t addr,
                             input word_t wdata, input word_t exp);
        tab_kind[tab_fill]  = kind;
        tab_addr[tab_fill]  = addr;
        tab_wdata[tab_fill] = wdata;
        tab_exp[tab_fill]   = exp;
        tab_fill++;
    endtask

    task automatic build_table();
        word_t w1;
        word_t w2;
        word_t w3;
        w1 = word_t'($random(seed));
        w2 = word_t'($random(seed));
        w3 = word_t'($random(seed));
        tab_fill = 0;
        // Cold instruction line, then a hit in it
        add_entry(IFETCH, 16'h0010, '0, pattern_word(16'h0010));
        add_entry(IFETCH, 16'h0013, '0, pattern_word(16'h0013));
        // Miss, hit, then two lines fighting over index 0
        add_entry(LOAD, 16'h0020, '0, pattern_word(16'h0020));
        add_entry(LOAD, 16'h0021, '0, pattern_word(16'h0021));
        add_entry(LOAD, 16'h0040, '0, pattern_word(16'h0040));
        add_entry(LOAD, 16'h0022, '0, pattern_word(16'h0022));
        add_entry(STORE, 16'h0030, w1, w1);
        add_entry(LOAD, 16'h0030, '0, w1);
        add_entry(LOAD, 16'h0031, '0, pattern_word(16'h0031));
        add_entry(LOAD, 16'h0033, '0, pattern_word(16'h0033));
        // Dirty line at index 1 evicted by 0x84
        add_entry(STORE, 16'h0064, w2, w2);
        add_entry(LOAD, 16'h0084, '0, pattern_word(16'h0084));
        add_entry(LOAD, 16'h0065, '0, pattern_word(16'h0065));
        add_entry(LOAD, 16'h0064, '0, w2);
        // Instruction side sees the written-back word
        add_entry(IFETCH, 16'h0064, '0, w2);
        add_entry(IFETCH, 16'h0066, '0, pattern_word(16'h0066));
        add_entry(STORE, 16'h0065, w3, w3);
        add_entry(LOAD, 16'h0065, '0, w3);
    endtask

    task automatic apply_entry(input int idx);
        int   waited;
        logic seen;
        @(posedge Clk);
        #1;
        chk_exp = tab_exp[idx];
        case (tab_kind[idx])
            IFETCH: begin
                chk_ifetch  = 1'b1;
                ifetch_addr = tab_addr[idx];
                ifetch_read = 1'b1;
            end
            LOAD: begin
                chk_load  = 1'b1;
                data_addr = tab_addr[idx];
                data_read = 1'b1;
            end
            default: begin
                chk_store  = 1'b1;
                data_addr  = tab_addr[idx];
                data_wdata = tab_wdata[idx];
                data_write = 1'b1;
            end
        endcase
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited <= MAX_WAIT) begin
            @(negedge Clk);
            if (tab_kind[idx] == IFETCH) begin
                seen = ifetch_done;
            end else begin
                seen = data_done;
            end
            if (!seen) begin
                waited++;
            end
        end
        if (!seen) begin
            $display("Timeout at %0t: entry %0d at address %h got no done within %0d cycles",
                     $time, idx, tab_addr[idx], MAX_WAIT);
            timeout_errors++;
        end
        @(posedge Clk);
        #1;
        ifetch_read = 1'b0;
        data_read   = 1'b0;
        data_write  = 1'b0;
        chk_ifetch  = 1'b0;
        chk_load    = 1'b0;
        chk_store   = 1'b0;
        @(posedge Clk);
    endtask

    // ************************************************************************
    // Main sequence
    // ************************************************************************

    initial begin
        seed           = 32'h665a;
        timeout_errors = 0;
        Clk            = 1'b0;
        i_arst_n       = 1'b0;
        ifetch_read    = 1'b0;
        ifetch_addr    = '0;
        data_read      = 1'b0;
        data_write     = 1'b0;
        data_addr      = '0;
        data_wdata     = '0;
        chk_ifetch     = 1'b0;
        chk_load       = 1'b0;
        chk_store      = 1'b0;
        chk_exp        = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge Clk);
        #1;
        i_arst_n = 1'b1;
        // Idle cycles catch a stray done right after reset
        repeat (3) @(posedge Clk);
        for (int i = 0; i < TABLE_LEN; i++) begin
            apply_entry(i);
        end
        repeat (2) @(posedge Clk);
        $display("Errors: data %0d, protocol %0d, timeout %0d",
                 data_errors, protocol_errors, timeout_errors);
        if (data_errors == 0 && protocol_errors == 0 && timeout_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the table did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: flist.f
cache_pkg.sv
mem_pkg.sv
icache.sv
dcache.sv
line_memory.sv
cache_top.sv
tb_checker.sv
tb_cache_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_cache_top
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation failed
PASS_MSG  = Simulation passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run ended early, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
